// ==== filelist.f ====
+incdir+logic
logic/rtf_bus_pkg.sv
logic/rtf_route_pkg.sv
logic/route_cfg_if.sv
logic/apb_reg_bank.sv
logic/pulse_gen.sv
logic/output_router.sv
logic/rtf_router_top.sv
verif/rtf_router_sva.sv
verif/rtf_router_tb.sv

// ==== Makefile ====
TOP := rtf_router_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall +incdir+logic --top-module rtf_router_top \
		logic/rtf_bus_pkg.sv logic/rtf_route_pkg.sv logic/route_cfg_if.sv \
		logic/apb_reg_bank.sv logic/pulse_gen.sv logic/output_router.sv \
		logic/rtf_router_top.sv

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/rtf_router_tb.sv ====
`timescale 1ns/1ps
`include "rtf_cfg.svh"

// Testbench for the trigger routing core
module rtf_router_tb import rtf_bus_pkg::*, rtf_route_pkg::*; ();

   localparam int N_REG     = 30;   // Random register write and read pairs
   localparam int N_ROUTE   = 200;
   localparam int N_OOR     = 60;
   localparam int N_PULSE   = 300;
   localparam int N_XFER    = 200;  // Upper bound on APB transfers
   localparam int LIMIT_CYC = 10 + 3 * N_XFER + N_ROUTE + N_OOR + 3 * N_PULSE + 500;
   localparam int W_PULSE   = int'(`RTF_REG_PULSE0) / 4;  // Word index of pulse 0
   localparam int W_MUX     = int'(`RTF_REG_MUX0) / 4;

   logic      clk_160;
   logic      reset;
   apb_addr_t paddr;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      pready;
   logic      pslverr;
   trig_vec_t trig_in;
   nim_vec_t  nim_out;
   rj45_vec_t rj45_out;

   // Reference model state
   period_t                 m_period [`RTF_N_PULSE];
   pulse_len_t              m_len    [`RTF_N_PULSE];
   period_t                 m_count  [`RTF_N_PULSE];
   logic [`RTF_N_PULSE-1:0] m_pulse;
   src_sel_t                m_sel    [`RTF_N_OUT];
   nim_vec_t                m_inv;
   logic                    m_clear;   // Soft clear strobe
   nim_vec_t                exp_nim;
   rj45_vec_t               exp_rj45;

   logic        check_on;              // Per-cycle output compare
   logic        rand_trig;             // New triggers every cycle
   logic [31:0] lfsr = 32'h62bb;

   rtf_router_top rtf_router_top_inst
   (
      .clk_160  (clk_160),
      .reset    (reset),
      .paddr    (paddr),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .trig_in  (trig_in),
      .nim_out  (nim_out),
      .rj45_out (rj45_out)
   );

   initial
   begin
      clk_160 = 1'b0;
      forever #5 clk_160 = ~clk_160;
   end

   initial
   begin
      #(LIMIT_CYC * 10);
      fail_run("watchdog expired before all tests completed");
   end

   // Fibonacci LFSR on taps 32 22 2 1 with one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
      if (got !== exp)
         fail_run($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_nim(input string name, input nim_vec_t got, input nim_vec_t exp);
      if (got !== exp)
         fail_run($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_rj45(input string name, input rj45_vec_t got, input rj45_vec_t exp);
      if (got !== exp)
         fail_run($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   // Model steps on the same edge as the DUT with inputs stable since 1 ns after the last edge
   always @(posedge clk_160)
   begin : model
      src_vec_t src;
      logic     pick;
      int       w;
      w = int'(paddr[`RTF_ADDR_W-1:2]);  // Byte lanes ignored
      if (reset)
      begin
         m_inv    = '0;
         m_clear  = 1'b0;
         m_pulse  = '0;
         exp_nim  = '0;
         exp_rj45 = '0;
         for (int p = 0; p < `RTF_N_PULSE; p++)
         begin
            m_period[p] = '0;
            m_len[p]    = '0;
            m_count[p]  = '0;
         end
         for (int k = 0; k < `RTF_N_OUT; k++)
            m_sel[k] = '0;
      end
      else
      begin
         src = {m_pulse, trig_in};  // Pulse values from before this edge
         for (int k = 0; k < `RTF_N_OUT; k++)
         begin
            pick = 1'b0;
            if (int'(m_sel[k]) < `RTF_N_SRC)
               pick = src[m_sel[k]];
            if (k < `RTF_N_NIM)
               exp_nim[k] = pick ^ m_inv[k];
            else
               exp_rj45[k - `RTF_N_NIM] = pick;
         end
         for (int p = 0; p < `RTF_N_PULSE; p++)
         begin
            m_pulse[p] = (m_period[p] != '0) && (m_count[p] < period_t'(m_len[p]));
            if (m_clear || (m_period[p] == '0) || (m_count[p] >= m_period[p] - 16'd1))
               m_count[p] = '0;  // Wrap, restart or held off
            else
               m_count[p] = m_count[p] + 16'd1;
         end
         m_clear = psel && penable && pwrite && (w == 0) && pwdata[0];
         if (psel && penable && pwrite)
         begin
            if (w >= W_PULSE && w < W_PULSE + `RTF_N_PULSE)
            begin
               m_period[w - W_PULSE] = pwdata[15:0];
               m_len[w - W_PULSE]    = pwdata[21:16];
            end
            if (w >= W_MUX && w < W_MUX + `RTF_N_OUT)
            begin
               m_sel[w - W_MUX] = pwdata[4:0];
               if (w < W_MUX + `RTF_N_NIM)
                  m_inv[w - W_MUX] = pwdata[8];  // NIM only
            end
         end
      end
   end

   // One clock then output compare and new triggers
   task automatic tick();
      @(posedge clk_160);
      #1;
      if (check_on)
      begin
         check_nim("nim_out", nim_out, exp_nim);
         check_rj45("rj45_out", rj45_out, exp_rj45);
      end
      if (rand_trig)
         trig_in = trig_vec_t'(rand_bits(`RTF_N_TRIG));
   endtask

   task automatic apb_xfer(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                           output apb_data_t rdata, output logic err);
      tick();
      paddr   = addr;   // Setup cycle
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      tick();
      penable = 1'b1;   // Access cycle
      #4;
      if (pready !== 1'b1)
         fail_run("pready was not high in the APB access cycle");
      rdata = prdata;
      err   = pslverr;
      tick();
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
      apb_data_t rdata;
      logic      err;
      apb_xfer(addr, 1'b1, wdata, rdata, err);
      check_flag("pslverr", err, 1'b0);
   endtask

   task automatic apb_read(input apb_addr_t addr, input apb_data_t exp, input logic exp_err);
      apb_data_t rdata;
      logic      err;
      apb_xfer(addr, 1'b0, '0, rdata, err);
      check_data("prdata", rdata, exp);
      check_flag("pslverr", err, exp_err);
   endtask

   initial
   begin
      apb_data_t  d;
      apb_data_t  mask;
      apb_addr_t  a;
      nim_vec_t   inv;
      period_t    per;
      pulse_len_t len;
      logic       err;
      int         k;
      int         w;
      reset     = 1'b1;
      paddr     = '0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      pwdata    = '0;
      trig_in   = '0;
      check_on  = 1'b0;
      rand_trig = 1'b0;
      inv       = '0;
      repeat (10) @(posedge clk_160);
      #1;
      reset    = 1'b0;
      check_on = 1'b1;

      // Reset state
      check_nim("nim_out", nim_out, '0);
      check_rj45("rj45_out", rj45_out, '0);
      for (w = 0; w < W_MUX + `RTF_N_OUT; w++)
         if (w != 3)
            apb_read(apb_addr_t'(4 * w), '0, 1'b0);  // Word 3 is a hole

      // Register map with random low address bits
      repeat (N_REG)
      begin
         k = int'(rand_bits(5)) % 18;
         d = rand_bits(32);
         if (k < `RTF_N_PULSE)
         begin
            a    = apb_addr_t'(int'(`RTF_REG_PULSE0) + 4 * k);
            mask = 32'h003f_ffff;
         end
         else
         begin
            a    = apb_addr_t'(int'(`RTF_REG_MUX0) + 4 * (k - 2));
            mask = (k - 2 < `RTF_N_NIM) ? 32'h0000_011f : 32'h0000_001f;
         end
         apb_write(a | apb_addr_t'(rand_bits(2)), d);
         apb_read(a, d & mask, 1'b0);
      end
      apb_write(`RTF_REG_CTRL, 32'h1);
      apb_read(`RTF_REG_CTRL, '0, 1'b0);  // Self-clearing
      repeat (8)
      begin
         w = (rand_bits(1) == 32'd1) ? 3 : 20 + int'(rand_bits(6)) % 44;
         a = apb_addr_t'(4 * w);
         apb_read(a, '0, 1'b1);
         apb_xfer(a, 1'b1, rand_bits(32), d, err);
         check_flag("pslverr", err, 1'b1);
      end

      // Routing with in-range selects
      rand_trig = 1'b1;
      for (k = 0; k < `RTF_N_OUT; k++)
         apb_write(apb_addr_t'(int'(`RTF_REG_MUX0) + 4 * k),
                   apb_data_t'(int'(rand_bits(5)) % 18) | (rand_bits(1) << 8));
      repeat (N_ROUTE) tick();

      // Out-of-range selects give constant outputs
      for (k = 0; k < `RTF_N_OUT; k++)
      begin
         d = apb_data_t'(18 + int'(rand_bits(4)) % 14) | (rand_bits(1) << 8);
         if (k < `RTF_N_NIM)
            inv[k] = d[8];
         apb_write(apb_addr_t'(int'(`RTF_REG_MUX0) + 4 * k), d);
      end
      tick();  // Outputs take the last select at this edge
      repeat (N_OOR)
      begin
         tick();
         check_rj45("rj45_out", rj45_out, '0);
         check_nim("nim_out", nim_out, inv);
      end

      // Pulses on outputs 0 1 4 5
      apb_write(`RTF_REG_MUX0, 32'd16);
      apb_write(`RTF_REG_MUX0 + 8'd4, 32'd17);
      apb_write(`RTF_REG_MUX0 + 8'd16, 32'd16);
      apb_write(`RTF_REG_MUX0 + 8'd20, 32'd17);
      per = period_t'(1 + int'(rand_bits(6)) % 40);
      len = pulse_len_t'(1 + int'(rand_bits(6)) % 63);
      apb_write(`RTF_REG_PULSE0, {10'd0, len, per});
      per = period_t'(1 + int'(rand_bits(3)));
      len = pulse_len_t'(per) + pulse_len_t'(rand_bits(3));  // Length not below period
      apb_write(`RTF_REG_PULSE0 + 8'd4, {10'd0, len, per});
      repeat (N_PULSE) tick();
      apb_write(`RTF_REG_PULSE0 + 8'd4, {10'd0, pulse_len_t'(rand_bits(6)), 16'd0});
      repeat (N_PULSE / 2) tick();

      // Soft clear mid-period
      per = period_t'(5 + int'(rand_bits(6)) % 50);
      len = pulse_len_t'(1 + int'(rand_bits(4)));
      apb_write(`RTF_REG_PULSE0 + 8'd4, {10'd0, len, per});
      repeat (N_PULSE / 2 + int'(rand_bits(3))) tick();
      apb_write(`RTF_REG_CTRL, 32'h1);
      repeat (N_PULSE) tick();

      $display("=== PASS ===");
      $finish;
   end

endmodule

// ==== verif/rtf_router_sva.sv ====
`timescale 1ns/1ps
`include "rtf_cfg.svh"

// APB handshake and reset checks on the top level ports
module rtf_router_sva import rtf_route_pkg::*;
(
   input logic      clk_160,
   input logic      reset,
   input logic      psel,
   input logic      penable,
   input logic      pready,
   input logic      pslverr,
   input nim_vec_t  nim_out,
   input rj45_vec_t rj45_out
);

   // Zero wait states, ready only in the access cycle
   a_pready : assert property (@(posedge clk_160) disable iff (reset)
                               pready == (psel && penable))
      else $error("pready differs from psel and penable");

   a_pslverr : assert property (@(posedge clk_160) pslverr |-> pready)
      else $error("pslverr high without pready");

   // Outputs cleared by each reset edge
   a_reset_out : assert property (@(posedge clk_160)
                                  reset |=> (nim_out == '0) && (rj45_out == '0))
      else $error("outputs not low during reset");

endmodule

bind rtf_router_top rtf_router_sva rtf_router_sva_inst
(
   .clk_160  (clk_160),
   .reset    (reset),
   .psel     (psel),
   .penable  (penable),
   .pready   (pready),
   .pslverr  (pslverr),
   .nim_out  (nim_out),
   .rj45_out (rj45_out)
);

// ==== logic/rtf_router_top.sv ====
`timescale 1ns/1ps
`include "rtf_cfg.svh"

// Trigger routing core
module rtf_router_top import rtf_bus_pkg::*; import rtf_route_pkg::*;
(
   input  logic      clk_160,
   input  logic      reset,

   // APB slave
   input  apb_addr_t paddr,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_data_t pwdata,
   output apb_data_t prdata,
   output logic      pready,
   output logic      pslverr,

   // Trigger I/O
   input  trig_vec_t trig_in,   // Back panel
   output nim_vec_t  nim_out,
   output rj45_vec_t rj45_out
);

   logic [`RTF_N_PULSE-1:0] pulse; // Pulse generator outputs

   route_cfg_if cfg_if ();

   apb_reg_bank apb_reg_bank_inst
   (
      .clk_160 (clk_160),
      .reset   (reset),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .cfg     (cfg_if.regs)
   );

   // One generator per pulse register
   for (genvar k = 0; k < `RTF_N_PULSE; k++)
   begin : gen_pulse
      pulse_gen pulse_gen_inst
      (
         .clk_160    (clk_160),
         .reset      (reset),
         .soft_clear (cfg_if.soft_clear),   // Shared restart
         .period     (cfg_if.pulse_period[k]),
         .length     (cfg_if.pulse_len[k]),
         .pulse      (pulse[k])
      );
   end

   output_router output_router_inst
   (
      .clk_160  (clk_160),
      .reset    (reset),
      .trig_in  (trig_in),
      .pulse    (pulse),
      .cfg      (cfg_if.router),
      .nim_out  (nim_out),
      .rj45_out (rj45_out)
   );

endmodule

// ==== logic/output_router.sv ====
`timescale 1ns/1ps
`include "rtf_cfg.svh"

// Source select per output, registered
module output_router import rtf_route_pkg::*;
(
   input  logic                    clk_160,
   input  logic                    reset,
   input  trig_vec_t               trig_in,
   input  logic [`RTF_N_PULSE-1:0] pulse,    // Already registered in pulse_gen
   route_cfg_if.router             cfg,
   output nim_vec_t                nim_out,
   output rj45_vec_t               rj45_out
);

   src_vec_t              src;     // Pulses above the triggers
   logic [`RTF_N_OUT-1:0] picked;  // Selected source per output

   assign src = {pulse, trig_in};

   always_comb
   begin
      for (int k = 0; k < `RTF_N_OUT; k++)
      begin
         // Selects past the last source give 0
         if (cfg.mux_sel[k] < `RTF_SEL_W'(`RTF_N_SRC))
         begin
            picked[k] = src[cfg.mux_sel[k]];
         end
         else
         begin
            picked[k] = 1'b0;
         end
      end
   end

   always_ff @(posedge clk_160)
   begin
      if (reset)
      begin
         nim_out  <= '0;
         rj45_out <= '0;
      end
      else
      begin
         nim_out  <= picked[`RTF_N_NIM-1:0] ^ cfg.nim_inv; // Invert after select
         rj45_out <= picked[`RTF_N_OUT-1:`RTF_N_NIM];
      end
   end

endmodule

// ==== logic/pulse_gen.sv ====
`timescale 1ns/1ps
`include "rtf_cfg.svh"

// Periodic pulse, restartable
module pulse_gen import rtf_route_pkg::*;
(
   input  logic       clk_160,
   input  logic       reset,
   input  logic       soft_clear,  // Restart from count 0
   input  period_t    period,      // 0 disables
   input  pulse_len_t length,
   output logic       pulse
);

   period_t count; // Position within the period

   always_ff @(posedge clk_160)
   begin
      if (reset)
      begin
         count <= '0;
         pulse <= 1'b0;
      end
      else
      begin
         // Wrap at period-1, also catches a period shrunk below count
         if (soft_clear || (period == '0) || (count >= period_t'(period - 1'b1)))
         begin
            count <= '0;
         end
         else
         begin
            count <= count + 1'b1;
         end

         // Length >= period gives a steady high
         pulse <= (period != '0) && (count < period_t'(length));
      end
   end

endmodule

// ==== logic/apb_reg_bank.sv ====
`timescale 1ns/1ps
`include "rtf_cfg.svh"

// APB slave, zero wait states
module apb_reg_bank import rtf_bus_pkg::*;
(
   input  logic      clk_160,
   input  logic      reset,
   input  apb_addr_t paddr,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_data_t pwdata,
   output apb_data_t prdata,
   output logic      pready,
   output logic      pslverr,
   route_cfg_if.regs cfg
);

   localparam int WORD_W   = `RTF_ADDR_W - 2;       // Word index width
   localparam int PULSE_IW = $clog2(`RTF_N_PULSE);
   localparam int MUX_IW   = $clog2(`RTF_N_OUT);
   localparam int NIM_IW   = $clog2(`RTF_N_NIM);
   localparam int LEN_LSB  = 16;                    // Length field in pulse reg
   localparam int INV_BIT  = 8;                     // Invert bit in mux reg

   logic [WORD_W-1:0] word;
   logic [WORD_W-1:0] pulse_off;  // Word offset from first pulse reg
   logic [WORD_W-1:0] mux_off;    // Word offset from first mux reg
   logic              hit_ctrl;
   logic              hit_pulse;
   logic              hit_mux;
   logic              hit_nim;    // Mux reg with a stored invert bit
   logic              access;
   logic              wr_en;

   assign word      = paddr[`RTF_ADDR_W-1:2]; // Byte lanes ignored
   assign pulse_off = word - WORD_W'(`RTF_REG_PULSE0 >> 2);
   assign mux_off   = word - WORD_W'(`RTF_REG_MUX0 >> 2);

   // Offsets below the base wrap high and miss
   assign hit_ctrl  = word == WORD_W'(`RTF_REG_CTRL >> 2);
   assign hit_pulse = pulse_off < WORD_W'(`RTF_N_PULSE);
   assign hit_mux   = mux_off < WORD_W'(`RTF_N_OUT);
   assign hit_nim   = hit_mux && (mux_off < WORD_W'(`RTF_N_NIM));

   assign access  = psel && penable;                          // Access phase
   assign wr_en   = access && pwrite;
   assign pready  = access;                                   // Never stalls
   assign pslverr = access && !(hit_ctrl || hit_pulse || hit_mux);

   // Read data, unused bits 0
   always_comb
   begin
      prdata = '0; // Control reg and holes read 0
      if (hit_pulse)
      begin
         prdata[`RTF_PERIOD_W-1:0]       = cfg.pulse_period[pulse_off[PULSE_IW-1:0]];
         prdata[LEN_LSB +: `RTF_LEN_W]   = cfg.pulse_len[pulse_off[PULSE_IW-1:0]];
      end
      else if (hit_mux)
      begin
         prdata[`RTF_SEL_W-1:0] = cfg.mux_sel[mux_off[MUX_IW-1:0]];
         if (hit_nim)
         begin
            prdata[INV_BIT] = cfg.nim_inv[mux_off[NIM_IW-1:0]]; // RJ45 has no invert
         end
      end
   end

   // Register writes land at the end of the access cycle
   always_ff @(posedge clk_160)
   begin
      if (reset)
      begin
         cfg.soft_clear <= 1'b0;
         cfg.nim_inv    <= '0;
         for (int k = 0; k < `RTF_N_PULSE; k++)
         begin
            cfg.pulse_period[k] <= '0;
            cfg.pulse_len[k]    <= '0;
         end
         for (int k = 0; k < `RTF_N_OUT; k++)
         begin
            cfg.mux_sel[k] <= '0; // All outputs on trigger 0
         end
      end
      else
      begin
         // High for one cycle only, never stored
         cfg.soft_clear <= wr_en && hit_ctrl && pwdata[0];

         if (wr_en && hit_pulse)
         begin
            cfg.pulse_period[pulse_off[PULSE_IW-1:0]] <= pwdata[`RTF_PERIOD_W-1:0];
            cfg.pulse_len[pulse_off[PULSE_IW-1:0]]    <= pwdata[LEN_LSB +: `RTF_LEN_W];
         end

         if (wr_en && hit_mux)
         begin
            cfg.mux_sel[mux_off[MUX_IW-1:0]] <= pwdata[`RTF_SEL_W-1:0];
            if (hit_nim)
            begin
               cfg.nim_inv[mux_off[NIM_IW-1:0]] <= pwdata[INV_BIT];
            end
         end
      end
   end

endmodule

// ==== logic/route_cfg_if.sv ====
`timescale 1ns/1ps
`include "rtf_cfg.svh"

// Register settings from the APB bank to pulse generators and router
interface route_cfg_if import rtf_route_pkg::*; ();

   logic       soft_clear;                    // One-cycle restart strobe
   period_t    pulse_period [`RTF_N_PULSE];
   pulse_len_t pulse_len    [`RTF_N_PULSE];
   src_sel_t   mux_sel      [`RTF_N_OUT];     // Source per output
   nim_vec_t   nim_inv;                       // NIM outputs only

   // Register bank owns every field
   modport regs
   (
      output soft_clear,
      output pulse_period,
      output pulse_len,
      output mux_sel,
      output nim_inv
   );

   // Pulse generators
   modport pulse
   (
      input soft_clear,
      input pulse_period,
      input pulse_len
   );

   // Output router
   modport router
   (
      input mux_sel,
      input nim_inv
   );

endinterface

// ==== logic/rtf_route_pkg.sv ====
`include "rtf_cfg.svh"

// Trigger routing side of the design
package rtf_route_pkg;

   typedef logic [`RTF_N_TRIG-1:0]   trig_vec_t;   // Back-panel triggers
   typedef logic [`RTF_N_SRC-1:0]    src_vec_t;    // Triggers plus pulses

   // Selects 18 to 31 route constant 0
   typedef logic [`RTF_SEL_W-1:0]    src_sel_t;

   typedef logic [`RTF_PERIOD_W-1:0] period_t;     // 0 holds the generator off
   typedef logic [`RTF_LEN_W-1:0]    pulse_len_t;  // High cycles per period

   typedef logic [`RTF_N_NIM-1:0]    nim_vec_t;    // Front NIM outputs
   typedef logic [`RTF_N_RJ45-1:0]   rj45_vec_t;   // Front RJ45 outputs

endpackage

// ==== logic/rtf_bus_pkg.sv ====
`include "rtf_cfg.svh"

// APB side of the design
package rtf_bus_pkg;

   // Byte address, low two bits ignored by the slave
   typedef logic [`RTF_ADDR_W-1:0] apb_addr_t;

   // Read and write data word
   typedef logic [`RTF_DATA_W-1:0] apb_data_t;

endpackage

// ==== logic/rtf_cfg.svh ====
`ifndef RTF_CFG_SVH
`define RTF_CFG_SVH

// Trigger and output counts
`define RTF_N_TRIG     16   // Back-panel trigger inputs
`define RTF_N_PULSE    2    // Periodic pulse generators
`define RTF_N_SRC      18   // Triggers 0-15, pulse 0 at 16, pulse 1 at 17
`define RTF_N_NIM      4    // NIM outputs, invertible
`define RTF_N_RJ45     12   // RJ45 outputs
`define RTF_N_OUT      16   // NIM 0-3 then RJ45 4-15

// Field widths
`define RTF_SEL_W      5    // Source select
`define RTF_PERIOD_W   16   // Pulse period in clk_160 cycles
`define RTF_LEN_W      6    // Pulse length in clk_160 cycles

// APB bus widths
`define RTF_ADDR_W     8
`define RTF_DATA_W     32

// Register byte offsets
`define RTF_REG_CTRL   8'h00  // Bit 0 soft clear, self-clearing
`define RTF_REG_PULSE0 8'h04  // Period 15..0, length 21..16, stride 4
`define RTF_REG_MUX0   8'h10  // Select 4..0, invert 8, stride 4

`endif
